//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= dmni_dma.f
TB_TOP    ?= dmni_dma_tb
RTL_TOP   ?= dmni_dma
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dmni_dma.f
source/dmni_pkg.sv
source/dma_receive.sv
source/dma_send.sv
source/dma_mem_arbiter.sv
source/dmni_dma.sv
verif/tb_memory.sv
verif/dmni_dma_tb.sv

//--- source/dma_mem_arbiter.sv
// DMA memory port arbiter

module dma_mem_arbiter #(
    parameter int unsigned SliceBits = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Requests
    input  logic               rcv_req_i,
    input  logic               snd_req_i,
    // Engine memory requests
    input  logic               rcv_en_i,
    input  dmni_pkg::byte_en_t rcv_we_i,
    input  dmni_pkg::addr_t    rcv_addr_i,
    input  logic               snd_en_i,
    input  dmni_pkg::addr_t    snd_addr_i,
    output dmni_pkg::grant_e   grant_o,
    // Memory port
    output logic               mem_en_o,
    output dmni_pkg::byte_en_t mem_we_o,
    output dmni_pkg::addr_t    mem_addr_o
);
    import dmni_pkg::*;

    grant_e               grant_q;
    grant_e               grant_d;
    grant_e               other;
    logic                 owner_req;
    logic                 other_req;
    logic [SliceBits-1:0] timer_q;

    //////////////////////////////////////////////////
    // Round robin with time slice
    //////////////////////////////////////////////////

    always_comb begin
        case (grant_q)
            GRANT_SEND: begin
                owner_req = snd_req_i;
                other     = GRANT_RECEIVE;
                other_req = rcv_req_i;
            end
            GRANT_RECEIVE: begin
                owner_req = rcv_req_i;
                other     = GRANT_SEND;
                other_req = snd_req_i;
            end
            default: begin
                owner_req = 1'b0;
                other     = GRANT_SEND;
                other_req = snd_req_i;
            end
        endcase
    end

    always_comb begin
        grant_d = grant_q;
        if (!rcv_req_i && !snd_req_i) begin
            grant_d = GRANT_NONE;
        end else if (other_req && (!owner_req || timer_q == '0)) begin
            grant_d = other;
        end else if (!owner_req) begin
            // Idle port, only receive asking
            grant_d = GRANT_RECEIVE;
        end
    end

    // Slice restarts whenever the owner lets go
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            grant_q <= GRANT_NONE;
            timer_q <= '1;
        end else begin
            grant_q <= grant_d;
            timer_q <= owner_req ? timer_q - SliceBits'(1) : '1;
        end
    end

    assign grant_o = grant_q;

    // Memory port mux, writes come from receive only
    always_comb begin
        case (grant_q)
            GRANT_SEND: begin
                mem_en_o   = snd_en_i;
                mem_we_o   = '0;
                mem_addr_o = snd_addr_i;
            end
            GRANT_RECEIVE: begin
                mem_en_o   = rcv_en_i;
                mem_we_o   = rcv_we_i;
                mem_addr_o = rcv_addr_i;
            end
            default: begin
                mem_en_o   = 1'b0;
                mem_we_o   = '0;
                mem_addr_o = '0;
            end
        endcase
    end

endmodule

//--- source/dma_receive.sv
// DMA receive engine

module dma_receive (
    input  logic               clk_i,
    input  logic               rst_ni,
    // NoC receive side
    input  logic               rx_i,
    input  logic               eop_i,
    input  dmni_pkg::word_t    flit_i,
    output logic               credit_o,
    // Software configuration
    input  logic               start_rcv_i,
    input  dmni_pkg::size_t    size_i,
    input  dmni_pkg::addr_t    addr_i,
    input  dmni_pkg::grant_e   grant_i,
    output dmni_pkg::word_t    rcv_header_o,
    output logic               rcv_available_o,
    output logic               rcv_active_o,
    output dmni_pkg::size_t    received_bytes_o,
    // Memory request
    output logic               mem_en_o,
    output dmni_pkg::byte_en_t mem_we_o,
    output dmni_pkg::addr_t    mem_addr_o
);
    import dmni_pkg::*;

    typedef enum logic [2:0] {
        RCV_HEADER = 3'b001,
        RCV_WAIT   = 3'b010,
        RCV_DATA   = 3'b100
    } rcv_state_e;

    rcv_state_e state_q;
    rcv_state_e state_d;
    addr_t      buf_addr_q;
    size_t      buf_size_q;
    logic       granted;
    logic       accept;
    logic       discard;
    logic       last_word;

    assign granted         = (grant_i == GRANT_RECEIVE);
    assign rcv_available_o = (state_q == RCV_WAIT);
    assign rcv_active_o    = (state_q == RCV_DATA);

    // Header is always taken, payload only while we own the memory
    assign credit_o  = (state_q == RCV_HEADER) || (rcv_active_o && granted);
    assign accept    = rcv_active_o && granted && rx_i;
    assign discard   = (buf_addr_q == '0);
    assign last_word = !discard && (buf_size_q == size_t'(1));

    //////////////////////////////////////////////////
    // Header and buffer
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (state_q == RCV_HEADER && rx_i) begin
            rcv_header_o <= flit_i;
        end
    end

    // Discarded payload leaves the counters alone until end-of-packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            buf_addr_q <= '0;
            buf_size_q <= '0;
        end else if (rcv_available_o) begin
            buf_addr_q <= addr_i;
            buf_size_q <= size_i;
        end else if (accept && !discard) begin
            buf_addr_q <= buf_addr_q + addr_t'(WORD_BYTES);
            buf_size_q <= buf_size_q - size_t'(1);
        end
    end

    //////////////////////////////////////////////////
    // Receive FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            RCV_HEADER: if (rx_i) state_d = RCV_WAIT;
            RCV_WAIT:   if (start_rcv_i) state_d = RCV_DATA;
            RCV_DATA: begin
                if (accept && eop_i) begin
                    state_d = RCV_HEADER;
                end else if (accept && last_word) begin
                    // Buffer full, wait for software to hand over another
                    state_d = RCV_WAIT;
                end
            end
            default: state_d = RCV_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RCV_HEADER;
        end else begin
            state_q <= state_d;
        end
    end

    // Byte count of the current transfer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            received_bytes_o <= '0;
        end else if (start_rcv_i) begin
            received_bytes_o <= '0;
        end else if (accept) begin
            received_bytes_o <= received_bytes_o + size_t'(WORD_BYTES);
        end
    end

    // Flit is written in the cycle it is accepted
    assign mem_en_o   = accept && !discard;
    assign mem_we_o   = {WORD_BYTES{mem_en_o}};
    assign mem_addr_o = buf_addr_q;

endmodule

//--- source/dma_send.sv
// DMA send engine

module dma_send (
    input  logic             clk_i,
    input  logic             rst_ni,
    // NoC send side
    input  logic             credit_i,
    output logic             tx_o,
    output logic             eop_o,
    // Software configuration
    input  logic             start_snd_i,
    input  dmni_pkg::size_t  size_i,
    input  dmni_pkg::size_t  size_2_i,
    input  dmni_pkg::addr_t  addr_i,
    input  dmni_pkg::addr_t  addr_2_i,
    input  dmni_pkg::grant_e grant_i,
    output logic             snd_active_o,
    // Memory request
    output logic             mem_en_o,
    output dmni_pkg::addr_t  mem_addr_o
);
    import dmni_pkg::*;

    typedef enum logic [3:0] {
        SND_IDLE    = 4'b0001,
        SND_PRELOAD = 4'b0010,
        SND_DATA    = 4'b0100,
        SND_STOP    = 4'b1000
    } snd_state_e;

    snd_state_e state_q;
    snd_state_e state_d;

    // Live segment counters
    addr_t addr_q;
    addr_t addr_2_q;
    size_t size_q;
    size_t size_2_q;

    // Counters as they stood before the last read was issued
    addr_t addr_s;
    addr_t addr_2_s;
    size_t size_s;
    size_t size_2_s;

    logic  can_send;
    logic  issue;
    logic  rollback;
    logic  last_word;

    assign can_send = credit_i && (grant_i == GRANT_SEND);
    assign issue    = can_send && (state_q inside {SND_PRELOAD, SND_DATA});

    // A flit is on the bus in DATA and STOP, and a drop there loses it
    assign rollback = !can_send && (state_q inside {SND_DATA, SND_STOP});

    // True when the read about to be issued fetches the final word
    assign last_word = ((size_q == size_t'(1)) && (size_2_q == '0))
                    || ((size_q == '0) && (size_2_q == size_t'(1)));

    //////////////////////////////////////////////////
    // Segment counters and rollback
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q   <= '0;
            addr_2_q <= '0;
            size_q   <= '0;
            size_2_q <= '0;
        end else if (state_q == SND_IDLE) begin
            addr_q   <= addr_i;
            addr_2_q <= addr_2_i;
            size_q   <= size_i;
            size_2_q <= size_2_i;
        end else if (issue) begin
            if (size_q != '0) begin
                addr_q <= addr_q + addr_t'(WORD_BYTES);
                size_q <= size_q - size_t'(1);
            end else if (size_2_q != '0) begin
                addr_2_q <= addr_2_q + addr_t'(WORD_BYTES);
                size_2_q <= size_2_q - size_t'(1);
            end
        end else if (rollback) begin
            addr_q   <= addr_s;
            addr_2_q <= addr_2_s;
            size_q   <= size_s;
            size_2_q <= size_2_s;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            addr_s   <= addr_q;
            addr_2_s <= addr_2_q;
            size_s   <= size_q;
            size_2_s <= size_2_q;
        end
    end

    //////////////////////////////////////////////////
    // Send FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            SND_IDLE: begin
                if (start_snd_i) begin
                    state_d = SND_PRELOAD;
                end
            end
            SND_PRELOAD, SND_DATA: begin
                if (!can_send) begin
                    state_d = SND_PRELOAD;
                end else if (last_word) begin
                    state_d = SND_STOP;
                end else begin
                    state_d = SND_DATA;
                end
            end
            SND_STOP: begin
                // Last flit refused, fetch it again
                state_d = can_send ? SND_IDLE : SND_PRELOAD;
            end
            default: state_d = SND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SND_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign tx_o         = (state_q inside {SND_DATA, SND_STOP}) && (grant_i == GRANT_SEND);
    assign eop_o        = (state_q == SND_STOP);
    assign snd_active_o = (state_q != SND_IDLE);

    // Segment one drains first
    assign mem_en_o   = issue;
    assign mem_addr_o = (size_q != '0) ? addr_q : addr_2_q;

endmodule

//--- source/dmni_dma.sv
// DMNI DMA engine top level

module dmni_dma #(
    parameter int unsigned SliceBits = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // NoC receive side
    input  logic               rx_i,
    input  logic               eop_i,
    input  dmni_pkg::word_t    flit_i,
    output logic               credit_o,
    // NoC send side
    output logic               tx_o,
    output logic               eop_o,
    input  logic               credit_i,
    output dmni_pkg::word_t    flit_o,
    // Memory port
    output logic               mem_en_o,
    output dmni_pkg::byte_en_t mem_we_o,
    output dmni_pkg::addr_t    mem_addr_o,
    output dmni_pkg::word_t    mem_data_o,
    input  dmni_pkg::word_t    mem_data_i,
    // Software configuration
    input  logic               start_rcv_i,
    input  logic               start_snd_i,
    input  dmni_pkg::size_t    size_i,
    input  dmni_pkg::size_t    size_2_i,
    input  dmni_pkg::addr_t    addr_i,
    input  dmni_pkg::addr_t    addr_2_i,
    output dmni_pkg::word_t    rcv_header_o,
    output logic               rcv_available_o,
    output logic               rcv_active_o,
    output logic               snd_active_o,
    output dmni_pkg::size_t    received_bytes_o
);
    import dmni_pkg::*;

    grant_e   grant;
    logic     rcv_mem_en;
    byte_en_t rcv_mem_we;
    addr_t    rcv_mem_addr;
    logic     snd_mem_en;
    addr_t    snd_mem_addr;

    //////////////////////////////////////////////////
    // Engines
    //////////////////////////////////////////////////

    dma_receive u_receive (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .rx_i             (rx_i),
        .eop_i            (eop_i),
        .flit_i           (flit_i),
        .credit_o         (credit_o),
        .start_rcv_i      (start_rcv_i),
        .size_i           (size_i),
        .addr_i           (addr_i),
        .grant_i          (grant),
        .rcv_header_o     (rcv_header_o),
        .rcv_available_o  (rcv_available_o),
        .rcv_active_o     (rcv_active_o),
        .received_bytes_o (received_bytes_o),
        .mem_en_o         (rcv_mem_en),
        .mem_we_o         (rcv_mem_we),
        .mem_addr_o       (rcv_mem_addr)
    );

    dma_send u_send (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .credit_i     (credit_i),
        .tx_o         (tx_o),
        .eop_o        (eop_o),
        .start_snd_i  (start_snd_i),
        .size_i       (size_i),
        .size_2_i     (size_2_i),
        .addr_i       (addr_i),
        .addr_2_i     (addr_2_i),
        .grant_i      (grant),
        .snd_active_o (snd_active_o),
        .mem_en_o     (snd_mem_en),
        .mem_addr_o   (snd_mem_addr)
    );

    // Active flags double as memory requests
    dma_mem_arbiter #(
        .SliceBits (SliceBits)
    ) u_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rcv_req_i  (rcv_active_o),
        .snd_req_i  (snd_active_o),
        .rcv_en_i   (rcv_mem_en),
        .rcv_we_i   (rcv_mem_we),
        .rcv_addr_i (rcv_mem_addr),
        .snd_en_i   (snd_mem_en),
        .snd_addr_i (snd_mem_addr),
        .grant_o    (grant),
        .mem_en_o   (mem_en_o),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o)
    );

    // Payload goes straight between NoC and memory
    assign mem_data_o = flit_i;
    assign flit_o     = mem_data_i;

endmodule

//--- source/dmni_pkg.sv
// DMA shared definitions

package dmni_pkg;

    //////////////////////////////////////////////////
    // Word geometry
    //////////////////////////////////////////////////

    // Flit and memory word share one width
    localparam int WORD_W = 32;

    // Address and byte-count step per word
    localparam int WORD_BYTES = WORD_W / 8;

    //////////////////////////////////////////////////
    // Datapath types
    //////////////////////////////////////////////////

    typedef logic [WORD_W-1:0] word_t;

    // Byte address into memory
    typedef logic [WORD_W-1:0] addr_t;

    // Word count of a buffer or segment
    typedef logic [WORD_W-1:0] size_t;

    // One write enable per byte lane
    typedef logic [WORD_BYTES-1:0] byte_en_t;

    //////////////////////////////////////////////////
    // Memory port ownership
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        GRANT_NONE    = 2'd0,
        GRANT_SEND    = 2'd1,
        GRANT_RECEIVE = 2'd2
    } grant_e;

endpackage

//--- verif/dma_input.txt
# name kind raddr rsize raddr2 rsize2 saddr ssize saddr2 ssize2 len drop
# kind 0 receive, 1 split receive, 2 send, 3 send with receive; addresses hex; drop 1 = credit drops
rcv_single 0 100 8 0 0 0 0 0 0 8 0
rcv_split 1 200 5 300 20 0 0 0 0 12 0
rcv_discard 0 0 10 0 0 0 0 0 0 10 0
snd_two_seg 2 0 0 0 0 400 6 500 5 11 0
snd_drops 2 0 0 0 0 600 9 700 7 16 1
snd_with_rcv 3 800 24 0 0 900 20 a00 12 24 1

//--- verif/dmni_dma_tb.sv
// DMNI DMA testbench

module dmni_dma_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import dmni_pkg::*;

    localparam word_t FILL_KEY = 32'h5A3C_96E1;

    typedef struct {
        string name;
        int    kind;
        int    raddr;
        int    rsize;
        int    raddr2;
        int    rsize2;
        int    saddr;
        int    ssize;
        int    saddr2;
        int    ssize2;
        int    len;
        int    drop;
    } test_rec_t;

    logic     clk_i;
    logic     rst_ni;
    logic     rx_i;
    logic     eop_i;
    word_t    flit_i;
    logic     credit_o;
    logic     tx_o;
    logic     eop_o;
    logic     credit_i;
    word_t    flit_o;
    logic     mem_en_o;
    byte_en_t mem_we_o;
    addr_t    mem_addr_o;
    word_t    mem_data_o;
    word_t    mem_data_i;
    logic     start_rcv_i;
    logic     start_snd_i;
    size_t    size_i;
    size_t    size_2_i;
    addr_t    addr_i;
    addr_t    addr_2_i;
    word_t    rcv_header_o;
    logic     rcv_available_o;
    logic     rcv_active_o;
    logic     snd_active_o;
    size_t    received_bytes_o;

    test_rec_t   tests[$];
    logic [31:0] lfsr;
    int          mismatches;
    int          failures;
    int          cycles;
    int          limit;

    dmni_dma #(
        .SliceBits (4)
    ) dut (.*);

    tb_memory #(
        .FillKey (FILL_KEY)
    ) u_mem (
        .clk_i  (clk_i),
        .en_i   (mem_en_o),
        .we_i   (mem_we_o),
        .addr_i (mem_addr_o),
        .data_i (mem_data_o),
        .data_o (mem_data_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Run limit, counted in clock cycles
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > limit) begin
            $display("ERROR: run did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic word_t fill_pattern(addr_t a);
        return a ^ FILL_KEY;
    endfunction

    task automatic check_word(string test, string what, word_t exp, word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test, what, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_size(string test, string what, size_t exp, size_t act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", test, what, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_bit(string test, string what, logic exp, logic act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %b, actual %b", test, what, exp, act);
            mismatches++;
        end
    endtask

    // Next drive point after the rising edge
    task automatic tick();
        @(posedge clk_i);
        #2;
    endtask

    task automatic load_tests();
        int        fd;
        int        n;
        string     line;
        test_rec_t t;
        fd = $fopen("verif/dma_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: stimulus file verif/dma_input.txt could not be opened");
            failures++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %h %d %h %d %h %d %h %d %d %d", t.name, t.kind,
                                t.raddr, t.rsize, t.raddr2, t.rsize2, t.saddr, t.ssize,
                                t.saddr2, t.ssize2, t.len, t.drop);
                    if (n == 12) begin
                        tests.push_back(t);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////
    // One test record
    //////////////////////////////////////////////////

    task automatic run_test(test_rec_t t);
        word_t       pay[$];
        word_t       exp_snd[$];
        word_t       header;
        addr_t       a;
        logic [31:0] draw;
        logic        rcv;
        logic        snd;
        logic        done;
        logic        pending;
        int          ri;
        int          si;
        int          stage;
        int          writes;
        rcv     = (t.kind != 2);
        snd     = (t.kind >= 2);
        ri      = 0;
        si      = 0;
        stage   = 0;
        writes  = 0;
        pending = 1'b0;
        header  = next_bits(32);
        for (int i = 0; i < t.len && rcv; i++) begin
            pay.push_back(next_bits(32));
        end
        for (int i = 0; i < t.ssize + t.ssize2 && snd; i++) begin
            a = (i < t.ssize) ? t.saddr + 4 * i : t.saddr2 + 4 * (i - t.ssize);
            exp_snd.push_back(fill_pattern(a));
        end
        if (rcv) begin
            rx_i   = 1'b1;
            flit_i = header;
            @(negedge clk_i);
            check_bit(t.name, "header credit", 1'b1, credit_o);
            tick();
            rx_i = 1'b0;
            @(negedge clk_i);
            while (!rcv_available_o) begin
                tick();
                @(negedge clk_i);
            end
            check_word(t.name, "header", header, rcv_header_o);
            tick();
            addr_i      = t.raddr;
            size_i      = t.rsize;
            start_rcv_i = 1'b1;
            tick();
            start_rcv_i = 1'b0;
        end
        if (snd) begin
            addr_i      = t.saddr;
            size_i      = t.ssize;
            addr_2_i    = t.saddr2;
            size_2_i    = t.ssize2;
            start_snd_i = 1'b1;
            tick();
            start_snd_i = 1'b0;
        end
        done = 1'b0;
        while (!done) begin
            rx_i        = rcv && ri < t.len;
            flit_i      = rx_i ? pay[ri] : '0;
            eop_i       = (ri == t.len - 1);
            draw        = (t.drop != 0) ? next_bits(1) : 32'd1;
            credit_i    = draw[0];
            start_rcv_i = pending;
            if (pending) begin
                addr_i = t.raddr2;
                size_i = t.rsize2;
            end
            pending = 1'b0;
            @(negedge clk_i);
            if (rx_i && credit_o) ri++;
            if (mem_en_o && mem_we_o != '0) writes++;
            if (tx_o && credit_i) begin
                if (si < exp_snd.size()) begin
                    check_word(t.name, "flit", exp_snd[si], flit_o);
                    check_bit(t.name, "eop", si == exp_snd.size() - 1, eop_o);
                end else begin
                    $display("ERROR: %s sent a flit beyond the end of the packet", t.name);
                    failures++;
                end
                si++;
            end
            if (t.kind == 1 && stage == 0 && rcv_available_o) begin
                check_size(t.name, "first buffer bytes", 4 * t.rsize, received_bytes_o);
                stage   = 1;
                pending = 1'b1;
            end
            done = (!rcv || (ri == t.len && !rcv_active_o && !rcv_available_o))
                && (!snd || (si == exp_snd.size() && !snd_active_o));
            tick();
        end
        rx_i     = 1'b0;
        eop_i    = 1'b0;
        credit_i = 1'b1;
        if (rcv) begin
            check_size(t.name, "received bytes",
                       4 * (t.kind == 1 ? t.len - t.rsize : t.len), received_bytes_o);
            for (int i = 0; i < t.len; i++) begin
                if (t.raddr == 0) begin
                    a = 4 * i;
                    check_word(t.name, "untouched word", fill_pattern(a), u_mem.mem[a[11:2]]);
                end else begin
                    a = (t.kind == 1 && i >= t.rsize) ? t.raddr2 + 4 * (i - t.rsize)
                                                      : t.raddr + 4 * i;
                    check_word(t.name, "memory word", pay[i], u_mem.mem[a[11:2]]);
                end
            end
            if (t.raddr == 0) begin
                check_size(t.name, "discard writes", 0, writes);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        rst_ni      = 1'b0;
        rx_i        = 1'b0;
        eop_i       = 1'b0;
        flit_i      = '0;
        credit_i    = 1'b1;
        start_rcv_i = 1'b0;
        start_snd_i = 1'b0;
        size_i      = '0;
        size_2_i    = '0;
        addr_i      = '0;
        addr_2_i    = '0;
        lfsr        = 32'd99136;
        mismatches  = 0;
        failures    = 0;
        cycles      = 0;
        limit       = 200;
        load_tests();
        // Receive packet and send packet of each record
        foreach (tests[i]) begin
            if (tests[i].kind != 2) begin
                limit += 8 * tests[i].len;
            end
            if (tests[i].kind >= 2) begin
                limit += 8 * (tests[i].ssize + tests[i].ssize2);
            end
        end
        repeat (8) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_bit("reset", "tx_o", 1'b0, tx_o);
        check_bit("reset", "mem_en_o", 1'b0, mem_en_o);
        check_bit("reset", "mem_we_o", 1'b0, mem_we_o != '0);
        check_bit("reset", "rcv_available_o", 1'b0, rcv_available_o);
        check_bit("reset", "rcv_active_o", 1'b0, rcv_active_o);
        check_bit("reset", "snd_active_o", 1'b0, snd_active_o);
        check_bit("reset", "credit_o", 1'b1, credit_o);
        check_size("reset", "received_bytes_o", 0, received_bytes_o);
        tick();
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display("Errors: %0d mismatches, %0d other failures over %0d tests",
                 mismatches, failures, tests.size());
        if (mismatches == 0 && failures == 0 && tests.size() > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_memory.sv
// Testbench word memory

module tb_memory #(
    parameter dmni_pkg::word_t FillKey = 32'h5A3C_96E1
) (
    input  logic               clk_i,
    input  logic               en_i,
    input  dmni_pkg::byte_en_t we_i,
    input  dmni_pkg::addr_t    addr_i,
    input  dmni_pkg::word_t    data_i,
    output dmni_pkg::word_t    data_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import dmni_pkg::*;

    localparam int Depth = 1024;

    word_t mem [Depth];

    // Every word starts as its own byte address mixed with the key
    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = addr_t'(i * WORD_BYTES) ^ FillKey;
        end
        data_o = '0;
    end

    always @(posedge clk_i) begin
        if (en_i && we_i != '0) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (we_i[b]) begin
                    mem[addr_i[11:2]][8*b +: 8] <= data_i[8*b +: 8];
                end
            end
        end else if (en_i) begin
            data_o <= mem[addr_i[11:2]];
        end
    end

endmodule
